/* src/lenet_cfg_pkg.sv */
package lenet_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arithmetic sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OPND_W      = 8;                     // weight or pixel.
    localparam int PROD_W      = 2 * OPND_W;            // full 8x8 product.

    localparam int KERNEL_TAPS = 25;                    // 5x5 window.
    localparam int TAP_W       = $clog2(KERNEL_TAPS);   // 5 bits.

    // 25 * 255 * 255 = 1625625 < 2**21.
    localparam int ACC_W       = PROD_W + 5;

    typedef logic [OPND_W-1:0] opnd_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [TAP_W-1:0]  tap_t;

endpackage

/* src/axil_map_pkg.sv */
package axil_map_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL    = 12'h000;    // bit 0 start, write only.
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS  = 12'h004;    // bit 0 busy, bit 1 done.
    localparam logic [AXI_ADDR_W-1:0] REG_RESULT  = 12'h008;    // read only.
    localparam logic [AXI_ADDR_W-1:0] WEIGHT_BASE = 12'h100;    // 25 words, stride 4.
    localparam logic [AXI_ADDR_W-1:0] PIXEL_BASE  = 12'h200;    // 25 words, stride 4.

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* src/approx_mul8x8.sv */
`timescale 1ns/1ps

module approx_mul8x8
    import lenet_cfg_pkg::*;
(
    input  opnd_t x,
    input  opnd_t y,
    output prod_t z
);

    localparam int CW = 13;     // correction word width.
    localparam int NC = 6;      // number of correction words.

    opnd_t         pp   [OPND_W];
    logic [CW-1:0] corr [NC];

    // one partial product row per bit of x.
    always_comb begin
        for (int i = 0; i < OPND_W; i++) begin
            pp[i] = y & {OPND_W{x[i]}};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lower six rows, folded pairwise into sparse words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int k = 0; k < NC; k++) begin
            corr[k] = '0;
        end

        // rows 0 and 1.
        corr[0][3]  = pp[0][3] & pp[1][2];
        corr[0][8]  = pp[1][7];

        // rows 2 and 3.
        corr[0][6]  = pp[2][3] ^ pp[3][2];
        corr[1][6]  = pp[2][4] | pp[3][3];
        corr[2][6]  = pp[2][4] ^ pp[3][3];
        corr[0][9]  = pp[2][6] & pp[3][5];
        corr[1][9]  = pp[2][6] | pp[3][5];
        corr[2][9]  = pp[2][7] & pp[3][6];
        corr[3][9]  = pp[2][7] | pp[3][6];
        corr[0][10] = pp[3][7];

        // rows 4 and 5.
        corr[0][5]  = pp[4][1] & pp[5][0];
        corr[0][7]  = pp[4][2] | pp[5][1];
        corr[1][8]  = pp[4][3] | pp[5][2];
        corr[2][8]  = pp[4][4] | pp[5][3];
        corr[4][9]  = pp[4][5] & pp[5][4];
        corr[5][9]  = pp[4][5] | pp[5][4];
        corr[0][11] = pp[4][6] & pp[5][5];
        corr[1][10] = pp[4][6] ^ pp[5][5];
        corr[0][12] = pp[4][7] & pp[5][6];
        corr[1][11] = pp[4][7] ^ pp[5][6];
        corr[1][12] = pp[5][7];
    end

    // top two rows stay exact.
    always_comb begin
        z = prod_t'({pp[6], 6'b0}) + prod_t'({pp[7], 7'b0});
        for (int k = 0; k < NC; k++) begin
            z = z + prod_t'(corr[k]);
        end
    end

endmodule

/* src/tap_bank.sv */
`timescale 1ns/1ps

module tap_bank
    import lenet_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  tap_t  waddr,
    input  opnd_t wdata,
    input  tap_t  raddr,
    output opnd_t rdata
);

    opnd_t mem [KERNEL_TAPS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // one cycle read latency.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    a_waddr_range: assert property (@(posedge clk)
        we |-> waddr < tap_t'(KERNEL_TAPS));

endmodule

/* src/tap_counter.sv */
`timescale 1ns/1ps

module tap_counter
    import lenet_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic step,
    output tap_t tap,
    output logic last
);

    assign last = (tap == tap_t'(KERNEL_TAPS - 1));

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            tap <= '0;
        end else if (step) begin
            tap <= last ? '0 : tap + 1'b1;  // wrap after tap 24.
        end
    end

    a_tap_range: assert property (@(posedge clk) disable iff (rst)
        tap < tap_t'(KERNEL_TAPS));

endmodule

/* src/conv_fsm.sv */
`timescale 1ns/1ps

module conv_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last,
    output logic busy,
    output logic done,
    output logic step,
    output logic cnt_clear,
    output logic acc_clear,
    output logic prod_valid,
    output logic acc_en
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   launch;

    assign launch    = start && ((state == IDLE) || (state == DONE));
    assign busy      = (state == RUN) || (state == DRAIN);
    assign done      = (state == DONE);
    assign step      = (state == RUN);     // one tap per cycle.
    assign cnt_clear = launch;
    assign acc_clear = launch;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: if (launch) state_nxt = RUN;
            RUN:        if (last) state_nxt = DRAIN;
            DRAIN:      if (!prod_valid) state_nxt = DONE;  // last product now in acc stage.
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            prod_valid <= 1'b0;
            acc_en     <= 1'b0;
        end else begin
            state      <= state_nxt;
            prod_valid <= step;         // bank read stage.
            acc_en     <= prod_valid;   // product register stage.
        end
    end

endmodule

/* src/mac_datapath.sv */
`timescale 1ns/1ps

module mac_datapath
    import lenet_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  acc_clear,
    input  logic  prod_valid,
    input  logic  acc_en,
    input  opnd_t weight,
    input  opnd_t pixel,
    output acc_t  acc
);

    prod_t          prod_c;
    prod_t          prod_q;
    logic [ACC_W:0] sum_ext;

    // rows gated by pixel bits, so pixels with zero low bits multiply exactly.
    approx_mul8x8 u_mul (
        .x (pixel),
        .y (weight),
        .z (prod_c)
    );

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            prod_q <= prod_c;
        end
    end

    assign sum_ext = {1'b0, acc} + (ACC_W + 1)'(prod_q);   // carry bit kept for check.

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (acc_clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= sum_ext[ACC_W-1:0];
        end
    end

    a_acc_no_wrap: assert property (@(posedge clk) disable iff (rst)
        acc_en |-> !sum_ext[ACC_W]);

endmodule

/* src/axil_regs.sv */
`timescale 1ns/1ps

module axil_regs
    import lenet_cfg_pkg::*;
    import axil_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic [AXI_STRB_W-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  weight_we,
    output logic                  pixel_we,
    output tap_t                  bank_waddr,
    output opnd_t                 bank_wdata,
    output logic                  start,
    input  logic                  busy,
    input  logic                  done,
    input  acc_t                  acc
);

    function automatic logic in_bank(logic [AXI_ADDR_W-1:0] addr,
                                     logic [AXI_ADDR_W-1:0] base);
        return (addr >= base) && (addr < base + AXI_ADDR_W'(4 * KERNEL_TAPS))
            && (addr[1:0] == 2'b00);
    endfunction

    function automatic tap_t bank_index(logic [AXI_ADDR_W-1:0] addr,
                                        logic [AXI_ADDR_W-1:0] base);
        logic [AXI_ADDR_W-1:0] off;
        off = addr - base;
        return off[2 +: TAP_W];
    endfunction

    logic                  wr_accept;
    logic                  rd_accept;
    logic                  wr_ctrl;
    logic                  wr_weight;
    logic                  wr_pixel;
    logic                  wr_bank_ok;
    logic [AXI_DATA_W-1:0] rd_data_c;
    logic [1:0]            rd_resp_c;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wr_accept  = awvalid && wvalid && !bvalid;   // held off while b pending.
    assign awready    = wr_accept;
    assign wready     = wr_accept;

    assign wr_ctrl    = (awaddr == REG_CTRL);
    assign wr_weight  = in_bank(awaddr, WEIGHT_BASE);
    assign wr_pixel   = in_bank(awaddr, PIXEL_BASE);
    assign wr_bank_ok = (wr_weight || wr_pixel) && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid    <= 1'b0;
            weight_we <= 1'b0;
            pixel_we  <= 1'b0;
            start     <= 1'b0;
        end else begin
            weight_we <= wr_accept && wr_weight && !busy && wstrb[0];
            pixel_we  <= wr_accept && wr_pixel && !busy && wstrb[0];
            start     <= wr_accept && wr_ctrl && wstrb[0] && wdata[0] && !busy;
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bank_waddr <= bank_index(awaddr, wr_weight ? WEIGHT_BASE : PIXEL_BASE);
            bank_wdata <= wdata[OPND_W-1:0];
            bresp      <= (wr_ctrl || wr_bank_ok) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    always_comb begin
        rd_data_c = '0;
        rd_resp_c = RESP_SLVERR;   // banks and ctrl are not readable.
        case (araddr)
            REG_STATUS: begin
                rd_data_c = AXI_DATA_W'({done, busy});
                rd_resp_c = RESP_OKAY;
            end
            REG_RESULT: begin
                rd_data_c = AXI_DATA_W'(acc);
                rd_resp_c = RESP_OKAY;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data_c;
            rresp <= rd_resp_c;
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* src/lenet_mac_top.sv */
`timescale 1ns/1ps

module lenet_mac_top
    import lenet_cfg_pkg::*;
    import axil_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic [AXI_STRB_W-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    logic  weight_we;
    logic  pixel_we;
    tap_t  bank_waddr;
    opnd_t bank_wdata;
    logic  start;
    logic  busy;
    logic  done;
    acc_t  acc;
    tap_t  tap;
    logic  last;
    logic  step;
    logic  cnt_clear;
    logic  acc_clear;
    logic  prod_valid;
    logic  acc_en;
    opnd_t weight_q;
    opnd_t pixel_q;

    axil_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .weight_we  (weight_we),
        .pixel_we   (pixel_we),
        .bank_waddr (bank_waddr),
        .bank_wdata (bank_wdata),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .acc        (acc)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand banks, both read at the current tap
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    tap_bank u_weight_bank (
        .clk   (clk),
        .we    (weight_we),
        .waddr (bank_waddr),
        .wdata (bank_wdata),
        .raddr (tap),
        .rdata (weight_q)
    );

    tap_bank u_pixel_bank (
        .clk   (clk),
        .we    (pixel_we),
        .waddr (bank_waddr),
        .wdata (bank_wdata),
        .raddr (tap),
        .rdata (pixel_q)
    );

    tap_counter u_tap_cnt (
        .clk   (clk),
        .rst   (rst),
        .clear (cnt_clear),
        .step  (step),
        .tap   (tap),
        .last  (last)
    );

    conv_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .last       (last),
        .busy       (busy),
        .done       (done),
        .step       (step),
        .cnt_clear  (cnt_clear),
        .acc_clear  (acc_clear),
        .prod_valid (prod_valid),
        .acc_en     (acc_en)
    );

    mac_datapath u_mac (
        .clk        (clk),
        .rst        (rst),
        .acc_clear  (acc_clear),
        .prod_valid (prod_valid),
        .acc_en     (acc_en),
        .weight     (weight_q),
        .pixel      (pixel_q),
        .acc        (acc)
    );

endmodule

/* tb/tb_lenet_mac.sv */
`timescale 1ns/1ps

module tb_lenet_mac
    import lenet_cfg_pkg::*;
    import axil_map_pkg::*;
();

    localparam int MODE_CONST    = 0;
    localparam int MODE_RAMP     = 1;
    localparam int MODE_RANDOM   = 2;
    localparam int MODE_EXACT    = 3;     // pixels multiple of 64.
    localparam int START_PLAIN   = 0;
    localparam int START_POKE    = 1;     // bank write while running.
    localparam int START_RESTART = 2;     // second start while running.
    localparam int NUM_CASES     = 7;
    localparam int HS_LIMIT      = 64;    // cycles allowed per handshake.
    localparam int POLL_LIMIT    = 40;

    typedef struct {
        int         mode;
        opnd_t      wparam;
        opnd_t      pparam;
        int         start_cond;
        logic [1:0] start_resp;
        logic [1:0] extra_resp;
    } case_t;

    logic                  clk;
    logic                  rst;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    case_t  cases  [NUM_CASES];
    opnd_t  w_vals [KERNEL_TAPS];
    opnd_t  p_vals [KERNEL_TAPS];
    integer seed         = 32'h4d95_b32d;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;

    lenet_mac_top uut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int place_bit(logic b, int pos);
        return b ? (1 << pos) : 0;
    endfunction

    function automatic prod_t approx_product(opnd_t x, opnd_t y);
        opnd_t r [OPND_W];
        int    sum;
        for (int i = 0; i < OPND_W; i++) begin
            r[i] = x[i] ? y : 8'h00;
        end
        sum = (int'(r[6]) << 6) + (int'(r[7]) << 7);   // exact upper rows.
        sum += place_bit(r[0][3] & r[1][2], 3);
        sum += place_bit(r[1][7], 8);
        sum += place_bit(r[2][3] ^ r[3][2], 6);
        sum += place_bit(r[2][4] | r[3][3], 6);
        sum += place_bit(r[2][4] ^ r[3][3], 6);
        sum += place_bit(r[2][6] & r[3][5], 9);
        sum += place_bit(r[2][6] | r[3][5], 9);
        sum += place_bit(r[2][7] & r[3][6], 9);
        sum += place_bit(r[2][7] | r[3][6], 9);
        sum += place_bit(r[3][7], 10);
        sum += place_bit(r[4][1] & r[5][0], 5);
        sum += place_bit(r[4][2] | r[5][1], 7);
        sum += place_bit(r[4][3] | r[5][2], 8);
        sum += place_bit(r[4][4] | r[5][3], 8);
        sum += place_bit(r[4][5] & r[5][4], 9);
        sum += place_bit(r[4][5] | r[5][4], 9);
        sum += place_bit(r[4][6] & r[5][5], 11);
        sum += place_bit(r[4][6] ^ r[5][5], 10);
        sum += place_bit(r[4][7] & r[5][6], 12);
        sum += place_bit(r[4][7] ^ r[5][6], 11);
        sum += place_bit(r[5][7], 12);
        return prod_t'(sum);
    endfunction

    function automatic acc_t conv_model();
        acc_t sum;
        sum = '0;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            sum += acc_t'(approx_product(p_vals[i], w_vals[i]));   // rows from pixel bits.
        end
        return sum;
    endfunction

    function automatic acc_t exact_model();
        acc_t sum;
        sum = '0;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            sum += acc_t'(w_vals[i]) * acc_t'(p_vals[i]);
        end
        return sum;
    endfunction

    function automatic string mode_name(int mode);
        case (mode)
            MODE_CONST:  return "const";
            MODE_RAMP:   return "ramp";
            MODE_RANDOM: return "random";
            default:     return "exact";
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_acc(acc_t got, acc_t exp, string what);
        if (got !== exp) begin
            $display("ERR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(logic [1:0] got, logic [1:0] exp, string what);
        if (got !== exp) begin
            $display("ERR at %0d ns: %s response %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(logic [AXI_DATA_W-1:0] got, logic [AXI_DATA_W-1:0] exp,
                                string what);
        if (got !== exp) begin
            $display("ERR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%-24s pass", name);
        end else begin
            tests_failed++;
            $display("%-24s fail, %0d errors", name, errors - errors_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic bus_write(input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        logic accepted;
        logic got;
        accepted = 1'b0;
        got      = 1'b0;
        resp     = 2'b11;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        for (int i = 0; i < HS_LIMIT && !accepted; i++) begin
            @(posedge clk);
            accepted = awready && wready;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!accepted) begin
            $display("write to 0x%03h was never accepted by the slave", addr);
            errors++;
            return;
        end
        for (int i = 0; i < HS_LIMIT && !got; i++) begin
            @(posedge clk);
            got  = bvalid && bready;
            resp = bresp;
        end
        if (!got) begin
            $display("write to 0x%03h never returned a response", addr);
            errors++;
        end
    endtask

    task automatic bus_read(input logic [AXI_ADDR_W-1:0] addr,
                            output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        logic accepted;
        logic got;
        accepted = 1'b0;
        got      = 1'b0;
        data     = '0;
        resp     = 2'b11;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        for (int i = 0; i < HS_LIMIT && !accepted; i++) begin
            @(posedge clk);
            accepted = arready;
        end
        @(negedge clk);
        arvalid = 1'b0;
        if (!accepted) begin
            $display("read of 0x%03h was never accepted by the slave", addr);
            errors++;
            return;
        end
        for (int i = 0; i < HS_LIMIT && !got; i++) begin
            @(posedge clk);
            got  = rvalid && rready;
            data = rdata;
            resp = rresp;
        end
        if (!got) begin
            $display("read of 0x%03h never returned data", addr);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        cases[0] = '{MODE_CONST,  8'hff, 8'hff, START_PLAIN,   RESP_OKAY, RESP_OKAY};
        cases[1] = '{MODE_EXACT,  8'h13, 8'h40, START_PLAIN,   RESP_OKAY, RESP_OKAY};
        cases[2] = '{MODE_RAMP,   8'h00, 8'hff, START_PLAIN,   RESP_OKAY, RESP_OKAY};
        cases[3] = '{MODE_RANDOM, 8'h00, 8'h00, START_PLAIN,   RESP_OKAY, RESP_OKAY};
        cases[4] = '{MODE_RANDOM, 8'h00, 8'h00, START_POKE,    RESP_OKAY, RESP_SLVERR};
        cases[5] = '{MODE_RAMP,   8'h5a, 8'h21, START_RESTART, RESP_OKAY, RESP_OKAY};
        cases[6] = '{MODE_CONST,  8'h81, 8'h7e, START_PLAIN,   RESP_OKAY, RESP_OKAY};
    endtask

    task automatic fill_operands(case_t c);
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            case (c.mode)
                MODE_CONST: begin
                    w_vals[i] = c.wparam;
                    p_vals[i] = c.pparam;
                end
                MODE_RAMP: begin
                    w_vals[i] = opnd_t'(c.wparam + i * 37);
                    p_vals[i] = opnd_t'(c.pparam + i * 53);
                end
                MODE_EXACT: begin
                    w_vals[i] = opnd_t'(c.wparam + i * 37);
                    p_vals[i] = opnd_t'(c.pparam + i * 53) & 8'hc0;
                end
                default: begin
                    w_vals[i] = opnd_t'($random(seed));
                    p_vals[i] = opnd_t'($random(seed));
                end
            endcase
        end
    endtask

    task automatic load_banks();
        logic [1:0] resp;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            bus_write(WEIGHT_BASE + AXI_ADDR_W'(4 * i), {24'h0, w_vals[i]}, resp);
            check_resp(resp, RESP_OKAY, "weight write");
            bus_write(PIXEL_BASE + AXI_ADDR_W'(4 * i), {24'h0, p_vals[i]}, resp);
            check_resp(resp, RESP_OKAY, "pixel write");
        end
    endtask

    task automatic reset_state_test();
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        int                    errors_before;
        errors_before = errors;
        bus_read(REG_STATUS, data, resp);
        check_resp(resp, RESP_OKAY, "status read");
        check_status(data, '0, "status after reset");
        bus_read(REG_RESULT, data, resp);
        check_resp(resp, RESP_OKAY, "result read");
        check_acc(acc_t'(data), '0, "result after reset");
        report_test("reset state", errors_before);
    endtask

    task automatic error_resp_test();
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        int                    errors_before;
        errors_before = errors;
        bus_read(WEIGHT_BASE + 12'h004, data, resp);
        check_resp(resp, RESP_SLVERR, "weight bank read");
        bus_read(PIXEL_BASE, data, resp);
        check_resp(resp, RESP_SLVERR, "pixel bank read");
        bus_read(REG_CTRL, data, resp);
        check_resp(resp, RESP_SLVERR, "ctrl read");
        bus_read(12'h300, data, resp);
        check_resp(resp, RESP_SLVERR, "unmapped read");
        bus_write(12'h300, 32'h1, resp);
        check_resp(resp, RESP_SLVERR, "unmapped write");
        bus_write(REG_STATUS, 32'h1, resp);
        check_resp(resp, RESP_SLVERR, "status write");
        bus_write(WEIGHT_BASE + 12'h064, 32'h1, resp);    // one past entry 24.
        check_resp(resp, RESP_SLVERR, "write past weight bank");
        bus_read(REG_STATUS, data, resp);
        check_status(data, '0, "status after bad accesses");
        report_test("error responses", errors_before);
    endtask

    task automatic backpressure_test();
        logic accepted;
        int   errors_before;
        errors_before = errors;
        accepted      = 1'b0;
        @(negedge clk);
        awaddr  = REG_CTRL;
        wdata   = '0;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        for (int i = 0; i < HS_LIMIT && !accepted; i++) begin
            @(posedge clk);
            accepted = awready;
        end
        if (!accepted) begin
            $display("first write of the back-pressure test was never accepted");
            errors++;
        end
        // second write stays presented while the first response is held.
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            if (!bvalid) begin
                $display("ERR at %0d ns: bvalid dropped while bready was low", $time);
                errors++;
            end
            if (awready) begin
                $display("ERR at %0d ns: write accepted while a response was pending", $time);
                errors++;
            end
        end
        @(negedge clk);
        bready = 1'b1;
        @(posedge clk);
        check_resp(bresp, RESP_OKAY, "held write");
        if (!bvalid || awready) begin
            $display("ERR at %0d ns: response handshake and next write overlapped", $time);
            errors++;
        end
        accepted = 1'b0;
        for (int i = 0; i < HS_LIMIT && !accepted; i++) begin
            @(posedge clk);
            accepted = awready;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!accepted) begin
            $display("second write was not accepted after the response completed");
            errors++;
        end
        @(posedge clk);
        check_resp(bresp, RESP_OKAY, "second write");
        report_test("write back-pressure", errors_before);
    endtask

    task automatic run_case(int idx);
        case_t                 c;
        acc_t                  expected;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        int                    errors_before;
        int                    polls;
        logic                  finished;
        c             = cases[idx];
        errors_before = errors;
        fill_operands(c);
        load_banks();
        expected = (c.mode == MODE_EXACT) ? exact_model() : conv_model();
        bus_write(REG_CTRL, 32'h1, resp);
        check_resp(resp, c.start_resp, "start write");
        if (c.start_cond == START_POKE) begin
            bus_write(WEIGHT_BASE + 12'h060, {24'h0, ~w_vals[24]}, resp);
            check_resp(resp, c.extra_resp, "bank write while busy");
        end else if (c.start_cond == START_RESTART) begin
            bus_write(REG_CTRL, 32'h1, resp);
            check_resp(resp, c.extra_resp, "start while busy");
        end
        bus_read(REG_STATUS, data, resp);
        check_status(data, 32'h1, "status after start");   // busy, done cleared.
        finished = 1'b0;
        polls    = 0;
        while (!finished && polls < POLL_LIMIT) begin
            bus_read(REG_STATUS, data, resp);
            finished = data[1];
            polls++;
        end
        if (!finished) begin
            $display("case %0d: done flag never set after %0d status polls", idx, POLL_LIMIT);
            errors++;
        end else begin
            check_status(data, 32'h2, "status at completion");
            bus_read(REG_RESULT, data, resp);
            check_resp(resp, RESP_OKAY, "result read");
            check_acc(acc_t'(data), expected, "result");
        end
        report_test($sformatf("case %0d %s", idx, mode_name(c.mode)), errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state_test();
        error_resp_test();
        backpressure_test();
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_CASES * 2000);
        $display("watchdog expired after %0d ns, run did not finish", NUM_CASES * 2000);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* tb.f */
src/lenet_cfg_pkg.sv
src/axil_map_pkg.sv
src/approx_mul8x8.sv
src/tap_bank.sv
src/tap_counter.sv
src/conv_fsm.sv
src/mac_datapath.sv
src/axil_regs.sv
src/lenet_mac_top.sv
tb/tb_lenet_mac.sv

/* Makefile */
# Verilator simulation of the LeNet MAC engine.

VERILATOR ?= verilator
TOP       ?= tb_lenet_mac
FILELIST  ?= tb.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
